//--- compile.f
src/proc_pkg.sv
src/proc_regfile.sv
src/proc_alu.sv
src/proc_dpath.sv
src/proc_ctrl.sv
src/proc_top.sv
sim/tb_clock_gen.sv
sim/proc_assert.sv
sim/proc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module proc_tb -f compile.f -o proc_sim \
  && ./obj_dir/proc_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

//--- sim/proc_assert.sv
// Protocol checker bound into proc_top.
// Watches reset behavior, the first fetch and store addresses.
`timescale 1ns/1ps
`default_nettype none

module proc_assert import proc_pkg::*; (
  input wire logic  clk,
  input wire logic  rst_n,
  input wire word_t imem_addr,
  input wire logic  dmem_wen,
  input wire word_t dmem_addr,
  input wire logic  to_mngr_val
);

  // Data window of the test memory
  localparam word_t data_lo = 32'h0000_2000;
  localparam word_t data_hi = 32'h0000_2100;

  // --------------------
  // Reset
  // --------------------
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (!to_mngr_val && !dmem_wen))
    else $error("manager strobe or store active during reset");

  a_first_fetch: assert property (@(posedge clk)
    $rose(rst_n) |-> (imem_addr == reset_vector))
    else $error("first fetch after reset is not at the reset vector");

  // --------------------
  // Running
  // --------------------
  // The squashed store after the taken branch points outside this window
  a_store_window: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen |-> (dmem_addr >= data_lo && dmem_addr < data_hi))
    else $error("store issued outside the data window");

endmodule

`default_nettype wire

//--- sim/proc_tb.sv
// Testbench for the five-stage core: program and data memories,
// manager source, and in-order check of every manager report.
`timescale 1ns/1ps
`default_nettype none

module proc_tb import proc_pkg::*;;

  localparam int timeout_cycles = 400;
  localparam int n_exp          = 11;

  logic  clk, rst_n;
  word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  word_t from_mngr_data, to_mngr_data;
  logic  dmem_wen, to_mngr_val;

  word_t prog [64];
  word_t dmem [64];
  word_t mngr_vals [16];
  word_t exp_vals [16];
  word_t imem_addr_q, dmem_addr_q;
  int    report_cnt, cycle_cnt;
  integer seed;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  proc_top u_dut (.*);

  bind proc_top proc_assert u_assert (.*);

  // --------------------
  // Encoders and memory helpers
  // --------------------
  function automatic word_t enc_r(input int rs, input int rt, input int rd, input func_t fn);
    return {op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic word_t enc_i(input opcode_t op, input int rs, input int rt,
                                  input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic word_t enc_cop0(input logic [4:0] kind, input int rt);
    return {op_cop0, kind, rt[4:0], 16'd0};
  endfunction

  // Preload pattern, mixes every address bit
  function automatic word_t dmem_fill(input word_t addr);
    return (addr * 32'd2654435761) ^ 32'h0F0F_0F0F;
  endfunction

  function automatic word_t fetch_word(input word_t addr);
    word_t off;
    off = addr - reset_vector;
    return (off < 32'd256) ? prog[off[7:2]] : 32'h0;
  endfunction

  function automatic word_t load_word(input word_t addr);
    word_t off;
    off = addr - 32'h2000;
    return (off < 32'd256) ? dmem[off[7:2]] : dmem_fill(addr);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic load_program();
    prog[0]  = enc_i(op_addiu, 0, 1, 16'd5);
    prog[1]  = enc_i(op_addiu, 0, 2, 16'd7);
    prog[2]  = enc_r(1, 2, 3, fn_addu);
    prog[3]  = enc_cop0(5'd4, 3);
    prog[4]  = enc_r(1, 2, 4, fn_subu);
    prog[5]  = enc_cop0(5'd4, 4);
    prog[6]  = enc_r(3, 2, 5, fn_and);
    prog[7]  = enc_r(3, 2, 6, fn_or);
    prog[8]  = enc_cop0(5'd4, 5);
    prog[9]  = enc_cop0(5'd4, 6);
    prog[10] = enc_r(4, 1, 7, fn_slt);
    prog[11] = enc_cop0(5'd4, 7);
    prog[12] = enc_i(op_ori, 0, 8, 16'h8001);
    prog[13] = enc_i(op_lui, 0, 9, 16'h1234);
    prog[14] = enc_i(op_addiu, 9, 10, 16'hFFFF);
    prog[15] = enc_cop0(5'd4, 8);
    prog[16] = enc_cop0(5'd4, 10);
    prog[17] = enc_i(op_ori, 0, 11, 16'h2000);
    prog[18] = enc_i(op_sw, 11, 3, 16'd8);
    prog[19] = enc_i(op_lw, 11, 12, 16'd8);
    prog[20] = enc_cop0(5'd4, 12);
    prog[21] = enc_i(op_lw, 11, 13, 16'd16);
    prog[22] = enc_cop0(5'd4, 13);
    // Taken beq skips a stray store and report
    prog[23] = enc_i(op_beq, 1, 1, 16'd2);
    prog[24] = enc_i(op_sw, 11, 3, 16'h1000);
    prog[25] = enc_cop0(5'd4, 1);
    prog[26] = enc_i(op_bne, 1, 2, 16'd2);
    prog[27] = enc_cop0(5'd4, 1);
    prog[28] = enc_cop0(5'd4, 2);
    // Spacer keeps earlier reports retired before mfc0 reaches D
    prog[29] = enc_i(op_addiu, 0, 15, 16'd1);
    prog[30] = enc_cop0(5'd0, 14);
    prog[31] = enc_cop0(5'd4, 14);
    prog[32] = {op_j, 26'h422};
    prog[33] = enc_cop0(5'd4, 1);
    prog[34] = enc_i(op_ori, 0, 16, 16'h1094);
    prog[35] = enc_r(16, 0, 0, fn_jr);
    prog[36] = enc_cop0(5'd4, 2);
    prog[37] = enc_r(14, 1, 17, fn_addu);
    prog[38] = enc_cop0(5'd4, 17);
    prog[39] = {op_j, 26'h427};
  endtask

  // --------------------
  // Memories and manager source
  // --------------------
  always @(posedge clk) begin
    imem_addr_q <= imem_addr;
    dmem_addr_q <= dmem_addr;
    if (dmem_wen && (dmem_addr - 32'h2000) < 32'd256) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  always @(negedge clk) begin
    imem_data      <= fetch_word(imem_addr_q);
    dmem_rdata     <= load_word(dmem_addr_q);
    from_mngr_data <= mngr_vals[report_cnt[3:0]];
  end

  // --------------------
  // Report checks
  // --------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n && to_mngr_val) begin
      assert (report_cnt < n_exp)
        else fail_run("Manager report seen after the last expected one");
      assert (to_mngr_data == exp_vals[report_cnt[3:0]])
        else fail_run($sformatf("FAILED at %0t: to_mngr_data expected %h actual %h",
                                $time, exp_vals[report_cnt[3:0]], to_mngr_data));
      report_cnt <= report_cnt + 1;
    end
  end

  initial begin
    imem_data      = '0;
    dmem_rdata     = '0;
    from_mngr_data = '0;
    report_cnt     = 0;
    cycle_cnt      = 0;
    seed           = 34991;
    for (int i = 0; i < 64; i++) begin
      prog[i] = 32'h0;
      dmem[i] = dmem_fill(32'h2000 + 4 * i);
    end
    for (int i = 0; i < 16; i++) begin
      mngr_vals[i] = $random(seed);
      exp_vals[i]  = '0;
    end
    load_program();

    exp_vals[0]  = 32'd5 + 32'd7;
    exp_vals[1]  = 32'd5 - 32'd7;
    exp_vals[2]  = 32'd12 & 32'd7;
    exp_vals[3]  = 32'd12 | 32'd7;
    exp_vals[4]  = ($signed(32'd5 - 32'd7) < $signed(32'd5)) ? 32'd1 : 32'd0;
    exp_vals[5]  = {16'h0000, 16'h8001};
    exp_vals[6]  = {16'h1234, 16'h0000} + 32'hFFFF_FFFF;
    exp_vals[7]  = 32'd12;
    exp_vals[8]  = dmem_fill(32'h2010);
    exp_vals[9]  = mngr_vals[9];
    exp_vals[10] = mngr_vals[9] + 32'd5;

    wait (report_cnt == n_exp || cycle_cnt >= timeout_cycles);
    if (report_cnt == n_exp) begin
      // A few more cycles to catch stray wrong-path reports
      repeat (10) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d reports",
                         cycle_cnt, report_cnt, n_exp));
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// Clock and reset source for the core testbench.
// 100 ns period, reset held low for the first two rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release lands on a falling edge, like all other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- src/proc_alu.sv
// Combinational ALU of the X stage.
// Also flags equal operands for beq and bne.
`timescale 1ns/1ps
`default_nettype none

module proc_alu import proc_pkg::*; (
  input  word_t   in0,
  input  word_t   in1,
  input  alu_fn_t fn,
  output word_t   out,
  output logic    ops_eq
);

  always_comb begin
    case (fn)
      alu_add: out = in0 + in1;
      alu_sub: out = in0 - in1;
      alu_and: out = in0 & in1;
      alu_or:  out = in0 | in1;
      // Signed compare
      alu_slt: out = {31'b0, $signed(in0) < $signed(in1)};
      // Shift amount taken from operand 0, lui sets it to sixteen
      alu_sll: out = in1 << in0[4:0];
      alu_cp1: out = in1;
      default: out = '0;
    endcase
  end

  assign ops_eq = (in0 == in1);

endmodule

`default_nettype wire

//--- src/proc_ctrl.sv
// Pipeline control: decode in D, per-stage control bits and valid bits,
// RAW stall, branch and jump squash, and the manager strobe
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl import proc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     inst_d,
  input  logic      br_cond_eq_x,
  output pc_sel_t   pc_sel_f,
  output logic      reg_en_f,
  output logic      reg_en_d,
  output logic      reg_en_x,
  output logic      reg_en_m,
  output logic      reg_en_w,
  output logic      squash_f,
  output op0_sel_t  op0_sel_d,
  output op1_sel_t  op1_sel_d,
  output alu_fn_t   alu_fn_x,
  output logic      wb_sel_m,
  output reg_addr_t rf_waddr_w,
  output logic      rf_wen_w,
  output logic      dmem_wen,
  output logic      to_mngr_val
);

  opcode_t   opcode_d;
  func_t     func_d;
  reg_addr_t rs_d, rt_d, waddr_d, waddr_x, waddr_m;
  alu_fn_t   alu_fn_d;
  logic      rs_en_d, rt_en_d, beq_d, bne_d, j_d, jr_d, lw_d, sw_d, wen_d, mtc0_d;
  logic      beq_x, bne_x, lw_x, sw_x, wen_x, mtc0_x, wen_m, mtc0_m, wen_w, mtc0_w;
  logic      val_f, val_d, val_x, val_m, val_w;
  logic      rs_hit, rt_hit, stall_d, squash_x, jump_d, go_x;

  assign opcode_d = inst_d[31:26];
  assign func_d   = inst_d[5:0];
  assign rs_d     = inst_d[25:21];
  assign rt_d     = inst_d[20:16];

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    op0_sel_d = op0_rs;
    op1_sel_d = op1_rt;
    alu_fn_d  = alu_add;
    waddr_d   = rt_d;
    {rs_en_d, rt_en_d, beq_d, bne_d, j_d, jr_d} = '0;
    {lw_d, sw_d, wen_d, mtc0_d} = '0;
    case (opcode_d)
      op_rtype: begin
        {rs_en_d, rt_en_d, wen_d} = 3'b111;
        waddr_d = inst_d[15:11];
        case (func_d)
          fn_addu: alu_fn_d = alu_add;
          fn_subu: alu_fn_d = alu_sub;
          fn_and:  alu_fn_d = alu_and;
          fn_or:   alu_fn_d = alu_or;
          fn_slt:  alu_fn_d = alu_slt;
          fn_jr:   {rt_en_d, wen_d, jr_d} = 3'b001;
          default: {rs_en_d, rt_en_d, wen_d} = 3'b000;
        endcase
      end
      op_addiu: {op1_sel_d, rs_en_d, wen_d} = {op1_simm, 2'b11};
      op_ori: begin
        {op1_sel_d, rs_en_d, wen_d} = {op1_zimm, 2'b11};
        alu_fn_d = alu_or;
      end
      op_lui: begin
        {op0_sel_d, op1_sel_d, wen_d} = {op0_sixteen, op1_zimm, 1'b1};
        alu_fn_d = alu_sll;
      end
      op_lw:  {op1_sel_d, rs_en_d, wen_d, lw_d} = {op1_simm, 3'b111};
      op_sw:  {op1_sel_d, rs_en_d, rt_en_d, sw_d} = {op1_simm, 3'b111};
      op_beq: {rs_en_d, rt_en_d, beq_d} = 3'b111;
      op_bne: {rs_en_d, rt_en_d, bne_d} = 3'b111;
      op_j:   j_d = 1'b1;
      op_cop0: begin
        alu_fn_d = alu_cp1;
        // rs field tells mfc0 from mtc0
        if (rs_d == 5'b00000) begin
          {op1_sel_d, wen_d} = {op1_mngr, 1'b1};
        end else if (rs_d == 5'b00100) begin
          {rt_en_d, mtc0_d} = 2'b11;
        end
      end
      default: ;
    endcase
  end

  // --------------------
  // Hazards and redirects
  // --------------------
  // Any valid writer ahead of D blocks the read until it leaves W
  assign rs_hit = (rs_d != '0) && ((val_x && wen_x && waddr_x == rs_d)
               || (val_m && wen_m && waddr_m == rs_d) || (val_w && wen_w && rf_waddr_w == rs_d));
  assign rt_hit = (rt_d != '0) && ((val_x && wen_x && waddr_x == rt_d)
               || (val_m && wen_m && waddr_m == rt_d) || (val_w && wen_w && rf_waddr_w == rt_d));

  assign squash_x = val_x && ((beq_x && br_cond_eq_x) || (bne_x && !br_cond_eq_x));
  assign stall_d  = val_d && !squash_x && ((rs_en_d && rs_hit) || (rt_en_d && rt_hit));
  assign jump_d   = val_d && !squash_x && !stall_d && (j_d || jr_d);
  assign go_x     = val_d && !squash_x && !stall_d;

  assign pc_sel_f = squash_x ? pc_br : (jump_d ? (jr_d ? pc_jr : pc_j) : pc_plus4);
  // Fetch slot is a bubble until the first word returns
  assign squash_f = squash_x || jump_d || !val_f;
  assign reg_en_f = !stall_d;
  assign reg_en_d = !stall_d;
  assign reg_en_x = go_x;
  assign reg_en_m = val_x;
  assign reg_en_w = val_m;

  // --------------------
  // Stage registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {val_f, val_d, val_x, val_m, val_w} <= '0;
    end else begin
      val_f <= 1'b1;
      if (reg_en_d) begin
        val_d <= !squash_f;
      end
      val_x <= go_x;
      val_m <= val_x;
      val_w <= val_m;
    end
  end

  always_ff @(posedge clk) begin
    if (go_x) begin
      alu_fn_x <= alu_fn_d;
      {beq_x, bne_x, lw_x, sw_x, wen_x, mtc0_x} <= {beq_d, bne_d, lw_d, sw_d, wen_d, mtc0_d};
      waddr_x <= waddr_d;
    end
    {wb_sel_m, wen_m, mtc0_m, waddr_m} <= {lw_x, wen_x, mtc0_x, waddr_x};
    {wen_w, mtc0_w, rf_waddr_w} <= {wen_m, mtc0_m, waddr_m};
  end

  assign rf_wen_w    = val_w && wen_w;
  assign to_mngr_val = val_w && mtc0_w;
  assign dmem_wen    = val_x && sw_x;

endmodule

`default_nettype wire

//--- src/proc_dpath.sv
// Datapath of the five-stage pipeline, F D X M W.
// All steering comes from proc_ctrl; memories sit outside the core.
`timescale 1ns/1ps
`default_nettype none

module proc_dpath import proc_pkg::*; #(
  parameter word_t reset_pc = reset_vector
) (
  input  logic      clk,
  input  logic      rst_n,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,
  input  word_t     dmem_rdata,
  input  word_t     from_mngr_data,
  output word_t     to_mngr_data,
  input  pc_sel_t   pc_sel_f,
  input  logic      reg_en_f,
  input  logic      reg_en_d,
  input  logic      reg_en_x,
  input  logic      reg_en_m,
  input  logic      reg_en_w,
  input  logic      squash_f,
  input  op0_sel_t  op0_sel_d,
  input  op1_sel_t  op1_sel_d,
  input  alu_fn_t   alu_fn_x,
  input  logic      wb_sel_m,
  input  reg_addr_t rf_waddr_w,
  input  logic      rf_wen_w,
  output word_t     inst_d,
  output logic      br_cond_eq_x
);

  // sll r0, r0, 0
  localparam word_t nop_inst = 32'h0000_0000;

  word_t pc_f, pc_plus4_f, pc_mux_f, pc_next_f;
  word_t br_target_x, j_target_d, jr_target_d;

  // --------------------
  // F stage
  // --------------------
  assign pc_plus4_f = pc_f + 32'd4;

  always_comb begin
    case (pc_sel_f)
      pc_br:   pc_mux_f = br_target_x;
      pc_jr:   pc_mux_f = jr_target_d;
      pc_j:    pc_mux_f = j_target_d;
      default: pc_mux_f = pc_plus4_f;
    endcase
  end

  // A held fetch re-issues its own address so the word comes back again
  assign pc_next_f = reg_en_f ? pc_mux_f : pc_f;
  assign imem_addr = pc_next_f;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= reset_pc - 32'd4;
    end else if (reg_en_f) begin
      pc_f <= pc_next_f;
    end
  end

  // --------------------
  // D stage
  // --------------------
  word_t pc_plus4_d, rdata0_d, rdata1_d, rf_wdata_w;
  word_t imm_sext_d, imm_zext_d, op0_d, op1_d, br_target_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_d <= nop_inst;
    end else if (reg_en_d) begin
      inst_d <= squash_f ? nop_inst : imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  proc_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (inst_d[25:21]),
    .rdata0 (rdata0_d),
    .raddr1 (inst_d[20:16]),
    .rdata1 (rdata1_d),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (rf_wdata_w)
  );

  assign imm_sext_d  = {{16{inst_d[15]}}, inst_d[15:0]};
  assign imm_zext_d  = {16'b0, inst_d[15:0]};
  assign br_target_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign j_target_d  = {pc_plus4_d[31:28], inst_d[25:0], 2'b00};
  assign jr_target_d = rdata0_d;

  // Operand muxes
  always_comb begin
    case (op0_sel_d)
      op0_shamt:   op0_d = {27'b0, inst_d[10:6]};
      op0_sixteen: op0_d = 32'd16;
      default:     op0_d = rdata0_d;
    endcase
    case (op1_sel_d)
      op1_simm: op1_d = imm_sext_d;
      op1_pc4:  op1_d = pc_plus4_d;
      op1_zimm: op1_d = imm_zext_d;
      op1_mngr: op1_d = from_mngr_data;
      default:  op1_d = rdata1_d;
    endcase
  end

  // --------------------
  // X stage
  // --------------------
  word_t op0_x, op1_x, sdata_x, alu_result_x;

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      op0_x       <= op0_d;
      op1_x       <= op1_d;
      sdata_x     <= rdata1_d;
      br_target_x <= br_target_d;
    end
  end

  proc_alu u_alu (
    .in0    (op0_x),
    .in1    (op1_x),
    .fn     (alu_fn_x),
    .out    (alu_result_x),
    .ops_eq (br_cond_eq_x)
  );

  assign dmem_addr  = alu_result_x;
  assign dmem_wdata = sdata_x;

  // --------------------
  // M and W stages
  // --------------------
  word_t ex_result_m, wb_result_w;

  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      ex_result_m <= alu_result_x;
    end
    if (reg_en_w) begin
      wb_result_w <= wb_sel_m ? dmem_rdata : ex_result_m;
    end
  end

  assign rf_wdata_w   = wb_result_w;
  assign to_mngr_data = wb_result_w;

endmodule

`default_nettype wire

//--- src/proc_pkg.sv
// Shared types and encodings for the five-stage core.
// Imported by every RTL module of the processor.
`default_nettype none

package proc_pkg;

  // Word and field widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  func_t;
  typedef logic [3:0]  alu_fn_t;
  typedef logic [1:0]  pc_sel_t;
  typedef logic [1:0]  op0_sel_t;
  typedef logic [2:0]  op1_sel_t;

  // --------------------
  // Instruction encodings
  // --------------------
  localparam opcode_t op_rtype = 6'b000000;
  localparam opcode_t op_addiu = 6'b001001;
  localparam opcode_t op_ori   = 6'b001101;
  localparam opcode_t op_lui   = 6'b001111;
  localparam opcode_t op_lw    = 6'b100011;
  localparam opcode_t op_sw    = 6'b101011;
  localparam opcode_t op_beq   = 6'b000100;
  localparam opcode_t op_bne   = 6'b000101;
  localparam opcode_t op_j     = 6'b000010;
  localparam opcode_t op_cop0  = 6'b010000;

  localparam func_t fn_addu = 6'b100001;
  localparam func_t fn_subu = 6'b100011;
  localparam func_t fn_and  = 6'b100100;
  localparam func_t fn_or   = 6'b100101;
  localparam func_t fn_slt  = 6'b101010;
  localparam func_t fn_jr   = 6'b001000;

  // ALU functions
  localparam alu_fn_t alu_add = 4'd0;
  localparam alu_fn_t alu_sub = 4'd1;
  localparam alu_fn_t alu_and = 4'd2;
  localparam alu_fn_t alu_or  = 4'd3;
  localparam alu_fn_t alu_slt = 4'd4;
  localparam alu_fn_t alu_sll = 4'd5;
  localparam alu_fn_t alu_cp1 = 4'd6;

  // --------------------
  // Mux selects
  // --------------------
  localparam pc_sel_t pc_br    = 2'd0;
  localparam pc_sel_t pc_jr    = 2'd1;
  localparam pc_sel_t pc_j     = 2'd2;
  localparam pc_sel_t pc_plus4 = 2'd3;

  localparam op0_sel_t op0_shamt   = 2'd0;
  localparam op0_sel_t op0_rs      = 2'd1;
  localparam op0_sel_t op0_sixteen = 2'd2;

  localparam op1_sel_t op1_rt   = 3'd0;
  localparam op1_sel_t op1_simm = 3'd1;
  localparam op1_sel_t op1_pc4  = 3'd2;
  localparam op1_sel_t op1_zimm = 3'd3;
  localparam op1_sel_t op1_mngr = 3'd4;

  // First fetch address
  localparam word_t reset_vector = 32'h0000_1000;

endpackage

`default_nettype wire

//--- src/proc_regfile.sv
// 32 x 32-bit register file, two combinational reads and one write port.
// Register 0 always reads as zero.
`timescale 1ns/1ps
`default_nettype none

module proc_regfile import proc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t raddr0,
  output word_t     rdata0,
  input  reg_addr_t raddr1,
  output word_t     rdata1,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [32];

  // No write lands while reset is held
  always_ff @(posedge clk) begin
    if (rst_n && wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Entry 0 is never written, so mask its read
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

//--- src/proc_top.sv
// Top of the processor core, control and datapath joined.
// Memories and the manager connect to its ports.
`timescale 1ns/1ps
`default_nettype none

module proc_top import proc_pkg::*; #(
  parameter word_t reset_pc = reset_vector
) (
  input  logic  clk,
  input  logic  rst_n,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t dmem_addr,
  output logic  dmem_wen,
  output word_t dmem_wdata,
  input  word_t dmem_rdata,
  input  word_t from_mngr_data,
  output word_t to_mngr_data,
  output logic  to_mngr_val
);

  // Control to datapath
  pc_sel_t   pc_sel_f;
  logic      reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w, squash_f;
  op0_sel_t  op0_sel_d;
  op1_sel_t  op1_sel_d;
  alu_fn_t   alu_fn_x;
  logic      wb_sel_m, rf_wen_w;
  reg_addr_t rf_waddr_w;

  // Datapath status
  word_t     inst_d;
  logic      br_cond_eq_x;

  proc_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_d       (inst_d),
    .br_cond_eq_x (br_cond_eq_x),
    .pc_sel_f     (pc_sel_f),
    .reg_en_f     (reg_en_f),
    .reg_en_d     (reg_en_d),
    .reg_en_x     (reg_en_x),
    .reg_en_m     (reg_en_m),
    .reg_en_w     (reg_en_w),
    .squash_f     (squash_f),
    .op0_sel_d    (op0_sel_d),
    .op1_sel_d    (op1_sel_d),
    .alu_fn_x     (alu_fn_x),
    .wb_sel_m     (wb_sel_m),
    .rf_waddr_w   (rf_waddr_w),
    .rf_wen_w     (rf_wen_w),
    .dmem_wen     (dmem_wen),
    .to_mngr_val  (to_mngr_val)
  );

  proc_dpath #(.reset_pc(reset_pc)) u_dpath (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data),
    .pc_sel_f       (pc_sel_f),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .squash_f       (squash_f),
    .op0_sel_d      (op0_sel_d),
    .op1_sel_d      (op1_sel_d),
    .alu_fn_x       (alu_fn_x),
    .wb_sel_m       (wb_sel_m),
    .rf_waddr_w     (rf_waddr_w),
    .rf_wen_w       (rf_wen_w),
    .inst_d         (inst_d),
    .br_cond_eq_x   (br_cond_eq_x)
  );

endmodule

`default_nettype wire
